//--- spi_cmd_top.f
+incdir+.
spi_cmd_pkg.sv
spi_cmd_apb_regs.sv
spi_cmd_tx.sv
spi_cmd_rx.sv
spi_cmd_engine.sv
spi_cmd_top.sv
tb_spi_slave_model.sv
tb_spi_cmd.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI command master testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='** FAIL **'

verilator --binary --assert --timescale 1ns/1ns \
  --top-module tb_spi_cmd -f spi_cmd_top.f \
  --Mdir obj_dir -o tb_spi_cmd
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_spi_cmd > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "$FAIL_MSG" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- tb_spi_cmd.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_cmd_params.svh"

module tb_spi_cmd
  import spi_cmd_pkg::*;
;

  localparam int NUM_TESTS = 10;
  localparam int NUM_FIXED = 5;
  localparam logic [31:0] LFSR_SEED = 32'h0aa7_5093;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 20 * 2 * `SPI_HALF_DIV * 2 + 200;

  typedef struct packed
  {
    cmd_t     cmd;
    rd_data_t resp;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  rd_data_t    resp;
  cmd_t        cmd_seen;
  int          pulse_cnt;
  entry_t      table_q [NUM_TESTS];
  logic [31:0] lfsr;
  int          cycles = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start_errors = 0;

  always #10 clk = ~clk;

  spi_cmd_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .sclk    (sclk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  tb_spi_slave_model i_slave (
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .resp      (resp),
    .miso      (miso),
    .cmd_seen  (cmd_seen),
    .pulse_cnt (pulse_cnt)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == test_start_errors)
      $display("Test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: FAILED", tests_run, name);
    end
    test_start_errors = errors;
  endtask

  // Setup and access phase on falling edges, sampled while the access phase is stable
  task automatic apb_access(input logic is_write, input apb_addr_t addr,
                            input apb_data_t wdata, output apb_data_t rdata,
                            output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = is_write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    check_value("pready", 32'(pready), 32'd1);  // No wait states in the access phase
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic wait_idle();
    apb_data_t status;
    logic      err;
    status = 32'd1;
    while (status[0])
      apb_access(1'b0, `SPI_REG_STATUS, '0, status, err);
  endtask

  task automatic run_entry(input int idx);
    entry_t    ent;
    apb_data_t rdata;
    logic      err;
    logic      is_write;
    ent      = table_q[idx];
    is_write = ent.cmd[`SPI_CMD_WIDTH-1];
    resp     = ent.resp;
    apb_access(1'b1, `SPI_REG_CMD, apb_data_t'(ent.cmd), rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    wait_idle();
    check_value("slave command", 32'(cmd_seen), 32'(ent.cmd));
    check_value("sclk pulses", 32'(pulse_cnt),
                is_write ? 32'd12 : 32'd20);
    apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
    check_value("STATUS", rdata, is_write ? 32'd0 : 32'd2);  // Bit 1 is rd_valid
    if (!is_write)
    begin
      apb_access(1'b0, `SPI_REG_RDATA, '0, rdata, err);
      check_value("RDATA", rdata, 32'(ent.resp));
      apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
      check_value("STATUS after RDATA", rdata, 32'd0);
    end
    report_test($sformatf("entry %0d cmd %h", idx, ent.cmd));
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the tests did not complete", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin
    apb_data_t rdata;
    logic      err;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    resp    = '0;
    lfsr    = LFSR_SEED;
    table_q[0] = '{12'h8A5, 8'h00};
    table_q[1] = '{12'h05C, 8'hC3};
    table_q[2] = '{12'hFFF, 8'hFF};  // All ones is a write
    table_q[3] = '{12'h000, 8'h00};  // All zeros is a read
    table_q[4] = '{12'h7FF, 8'hFF};
    for (int i = NUM_FIXED; i < NUM_TESTS; i++)
    begin
      table_q[i].cmd  = cmd_t'(take_bits(`SPI_CMD_WIDTH));
      table_q[i].resp = rd_data_t'(take_bits(`SPI_READ_WIDTH));
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_value("cs_n", 32'(cs_n), 32'd1);
    check_value("sclk", 32'(sclk), 32'd0);
    check_value("mosi", 32'(mosi), 32'd0);
    apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
    check_value("STATUS", rdata, 32'd0);
    check_value("pslverr", 32'(err), 32'd0);
    report_test("reset state");

    for (int i = 0; i < NUM_TESTS; i++)
      run_entry(i);

    // Second command lands while the first frame is running
    resp = 8'h5A;
    apb_access(1'b1, `SPI_REG_CMD, 32'h0000_0A5A, rdata, err);
    check_value("pslverr", 32'(err), 32'd0);
    apb_access(1'b1, `SPI_REG_CMD, 32'h0000_03C3, rdata, err);
    check_value("pslverr", 32'(err), 32'd1);
    wait_idle();
    check_value("slave command", 32'(cmd_seen), 32'h0000_0A5A);
    check_value("sclk pulses", 32'(pulse_cnt), 32'd12);
    report_test("busy refusal");

    apb_access(1'b0, 8'h0C, '0, rdata, err);
    check_value("pslverr", 32'(err), 32'd1);
    apb_access(1'b1, 8'h10, 32'h0000_0FFF, rdata, err);
    check_value("pslverr", 32'(err), 32'd1);
    apb_access(1'b0, `SPI_REG_STATUS, '0, rdata, err);
    check_value("STATUS", rdata, 32'd0);
    report_test("unknown address");

    $display("Summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb_spi_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_cmd_params.svh"

module tb_spi_slave_model
  import spi_cmd_pkg::*;
(
  input  wire           sclk,
  input  wire           cs_n,
  input  wire           mosi,
  input  wire rd_data_t resp,       // Byte returned in a read frame
  output logic          miso,
  output cmd_t          cmd_seen,   // First command bits of the current frame
  output int            pulse_cnt   // Rising sclk edges while selected
);

  logic miso_q = 1'b0;

  assign miso = miso_q;

  // sclk is parked low when cs_n falls, so its level tells the two events apart
  always @(posedge sclk or negedge cs_n)
  begin
    if (!sclk)
    begin
      pulse_cnt <= 0;
      cmd_seen  <= '0;
    end
    else if (!cs_n)
    begin
      if (pulse_cnt < `SPI_CMD_WIDTH)
        cmd_seen <= {cmd_seen[`SPI_CMD_WIDTH-2:0], mosi};
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  // Mode 0 slave: change miso on the falling edge, MSB first, after the command
  always @(negedge sclk or posedge cs_n)
  begin
    if (cs_n)
      miso_q <= 1'b0;
    else if (!cmd_seen[`SPI_CMD_WIDTH-1] && (pulse_cnt >= `SPI_CMD_WIDTH) &&
             (pulse_cnt < `SPI_CMD_WIDTH + `SPI_READ_WIDTH))
      miso_q <= 1'(resp >> (`SPI_CMD_WIDTH + `SPI_READ_WIDTH - 1 - pulse_cnt));
  end

endmodule

`default_nettype wire

//--- spi_cmd_top.sv
`timescale 1ns/1ns
`default_nettype none

module spi_cmd_top
  import spi_cmd_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire            psel,
  input  wire            penable,
  input  wire            pwrite,
  input  wire apb_addr_t paddr,
  input  wire apb_data_t pwdata,
  output apb_data_t      prdata,
  output logic           pready,
  output logic           pslverr,
  output logic           sclk,
  output logic           cs_n,
  output logic           mosi,
  input  wire            miso
);

  logic     cmd_start;
  cmd_t     cmd_word;
  logic     busy;
  logic     read_vld;
  rd_data_t read_data;
  logic     tx_load;
  cmd_t     tx_word;
  logic     fall_tick;
  logic     rise_tick;
  logic     tx_done;
  logic     rx_en;
  logic     rx_done;
  rd_data_t rx_byte;

  spi_cmd_apb_regs i_apb_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .busy      (busy),
    .read_vld  (read_vld),
    .read_data (read_data),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word)
  );

  spi_cmd_engine i_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_start (cmd_start),
    .cmd_word  (cmd_word),
    .tx_done   (tx_done),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .busy      (busy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .tx_load   (tx_load),
    .tx_word   (tx_word),
    .fall_tick (fall_tick),
    .rise_tick (rise_tick),
    .rx_en     (rx_en),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_cmd_tx i_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .tx_load   (tx_load),
    .tx_word   (tx_word),
    .fall_tick (fall_tick),
    .rise_tick (rise_tick),
    .mosi      (mosi),
    .tx_done   (tx_done)
  );

  spi_cmd_rx i_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_en     (rx_en),
    .rise_tick (rise_tick),
    .miso      (miso),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte)
  );

endmodule

`default_nettype wire

//--- spi_cmd_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_cmd_params.svh"

module spi_cmd_engine
  import spi_cmd_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire           cmd_start,
  input  wire cmd_t     cmd_word,
  input  wire           tx_done,
  input  wire           rx_done,
  input  wire rd_data_t rx_byte,
  output logic          busy,
  output logic          sclk,
  output logic          cs_n,
  output logic          tx_load,
  output cmd_t          tx_word,
  output logic          fall_tick,
  output logic          rise_tick,
  output logic          rx_en,
  output logic          read_vld,
  output rd_data_t      read_data
);

  localparam int DIV_W = (`SPI_HALF_DIV > 1) ? $clog2(`SPI_HALF_DIV) : 1;

  engine_state_t    state;
  engine_state_t    state_next;
  logic [DIV_W-1:0] div_cnt;
  logic             tick;         // End of an sclk half-period
  logic             finish_done;
  cmd_t             cmd_q;

  assign tick        = (state != IDLE) && (div_cnt == DIV_W'(`SPI_HALF_DIV - 1));
  assign finish_done = (state == FINISH) && tick && !sclk;

  // No new rising edge once the frame is finishing
  assign rise_tick = tick && !sclk && (state != FINISH);
  assign fall_tick = tick && sclk;

  assign busy    = (state != IDLE);
  assign rx_en   = (state == READ_PHASE);
  assign tx_word = cmd_q;

  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
        if (cmd_start)
          state_next = CMD_PHASE;
      CMD_PHASE:
        if (tx_done)
          state_next = cmd_q[`SPI_CMD_WIDTH-1] ? FINISH : READ_PHASE;
      READ_PHASE:
        if (rx_done)
          state_next = FINISH;
      FINISH:
        if (finish_done)
          state_next = IDLE;
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      div_cnt  <= '0;
      sclk     <= 1'b0;
      cs_n     <= 1'b1;
      tx_load  <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      state    <= state_next;
      tx_load  <= (state == IDLE) && cmd_start;
      read_vld <= finish_done && !cmd_q[`SPI_CMD_WIDTH-1];
      if (state == IDLE)
      begin
        div_cnt <= '0;
        sclk    <= 1'b0;
      end
      else if (tick)
      begin
        div_cnt <= '0;
        if (sclk || (state != FINISH))
          sclk <= !sclk;
      end
      else
        div_cnt <= div_cnt + 1'b1;
      if ((state == IDLE) && cmd_start)
        cs_n <= 1'b0;
      else if (finish_done)
        cs_n <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == IDLE) && cmd_start)
      cmd_q <= cmd_word;
    if ((state == READ_PHASE) && rx_done)
      read_data <= rx_byte;
  end

  // The bus clock must be parked low outside a frame
  a_sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk);

endmodule

`default_nettype wire

//--- spi_cmd_rx.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_cmd_params.svh"

module spi_cmd_rx
  import spi_cmd_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  wire      rx_en,
  input  wire      rise_tick,
  input  wire      miso,
  output logic     rx_done,
  output rd_data_t rx_byte
);

  localparam int CNT_W = $clog2(`SPI_READ_WIDTH + 1);

  logic [CNT_W-1:0] bit_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_en)
        bit_cnt <= '0;
      else if (rise_tick)
      begin
        if (bit_cnt == CNT_W'(`SPI_READ_WIDTH - 1))
        begin
          bit_cnt <= '0;
          rx_done <= 1'b1;  // rx_byte is complete in the same cycle
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_en && rise_tick)
      rx_byte <= {rx_byte[`SPI_READ_WIDTH-2:0], miso};
  end

endmodule

`default_nettype wire

//--- spi_cmd_tx.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_cmd_params.svh"

module spi_cmd_tx
  import spi_cmd_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       tx_load,
  input  wire cmd_t tx_word,
  input  wire       fall_tick,
  input  wire       rise_tick,
  output logic      mosi,
  output logic      tx_done
);

  localparam int CNT_W = $clog2(`SPI_CMD_WIDTH + 1);

  cmd_t             shift_q;
  logic [CNT_W-1:0] bit_cnt;  // Rising edges seen in this frame

  assign mosi = shift_q[`SPI_CMD_WIDTH-1];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q <= '0;
      bit_cnt <= '0;
      tx_done <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (tx_load)
      begin
        shift_q <= tx_word;  // MSB goes straight onto mosi
        bit_cnt <= '0;
      end
      else
      begin
        if (fall_tick)
          shift_q <= {shift_q[`SPI_CMD_WIDTH-2:0], 1'b0};
        if (rise_tick && (bit_cnt < CNT_W'(`SPI_CMD_WIDTH)))
        begin
          bit_cnt <= bit_cnt + 1'b1;
          tx_done <= (bit_cnt == CNT_W'(`SPI_CMD_WIDTH - 1));
        end
      end
    end
  end

  // The slave samples on the rising edge, so mosi has to hold across it
  a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rise_tick |=> $stable(mosi));

endmodule

`default_nettype wire

//--- spi_cmd_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "spi_cmd_params.svh"

module spi_cmd_apb_regs
  import spi_cmd_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire            psel,
  input  wire            penable,
  input  wire            pwrite,
  input  wire apb_addr_t paddr,
  input  wire apb_data_t pwdata,
  input  wire            busy,
  input  wire            read_vld,
  input  wire rd_data_t  read_data,
  output apb_data_t      prdata,
  output logic           pready,
  output logic           pslverr,
  output logic           cmd_start,
  output cmd_t           cmd_word
);

  logic     access;
  logic     addr_cmd;
  logic     addr_status;
  logic     addr_rdata;
  logic     cmd_wr;
  logic     cmd_refuse;
  logic     rdata_rd;
  logic     rd_valid;
  rd_data_t rdata_q;

  assign access      = psel && penable;
  assign addr_cmd    = (paddr == `SPI_REG_CMD);
  assign addr_status = (paddr == `SPI_REG_STATUS);
  assign addr_rdata  = (paddr == `SPI_REG_RDATA);

  assign cmd_wr     = access && pwrite && addr_cmd;
  assign cmd_refuse = cmd_wr && (busy || cmd_start);  // A launch already in flight counts as busy
  assign rdata_rd   = access && !pwrite && addr_rdata;

  assign pready  = 1'b1;
  assign pslverr = access && (!(addr_cmd || addr_status || addr_rdata) || cmd_refuse);

  // Read data must be valid during the access phase, so the mux is combinational
  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      if (addr_status)
        prdata = {30'd0, rd_valid, busy};
      else if (addr_rdata)
        prdata = apb_data_t'(rdata_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd_start <= 1'b0;
      rd_valid  <= 1'b0;
    end
    else
    begin
      cmd_start <= cmd_wr && !cmd_refuse;
      if (read_vld)
        rd_valid <= 1'b1;  // New byte wins over a clearing read in the same cycle
      else if (rdata_rd)
        rd_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_wr && !cmd_refuse)
      cmd_word <= pwdata[`SPI_CMD_WIDTH-1:0];
    if (read_vld)
      rdata_q <= read_data;
  end

  // The engine must be idle whenever a new frame is launched
  a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_start |-> !busy);

endmodule

`default_nettype wire

//--- spi_cmd_pkg.sv
`default_nettype none

`include "spi_cmd_params.svh"

package spi_cmd_pkg;

  // One command word as written to CMD
  typedef logic [`SPI_CMD_WIDTH-1:0] cmd_t;

  typedef logic [`SPI_READ_WIDTH-1:0] rd_data_t;  // Byte returned by a read frame

  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Frame sequencing in the engine
  typedef enum logic [1:0]
  {
    IDLE,
    CMD_PHASE,   // Command bits going out on mosi
    READ_PHASE,  // Response byte coming in on miso
    FINISH       // Last falling edge, then cs_n release
  } engine_state_t;

endpackage

`default_nettype wire

//--- spi_cmd_params.svh
`ifndef SPI_CMD_PARAMS_SVH
`define SPI_CMD_PARAMS_SVH

// Frame geometry. Bit SPI_CMD_WIDTH-1 of a command is the write flag
`define SPI_CMD_WIDTH 12
`define SPI_READ_WIDTH 8

`define SPI_HALF_DIV 2  // System clocks per sclk half-period

// APB register map
`define SPI_REG_CMD 8'h00
`define SPI_REG_STATUS 8'h04
`define SPI_REG_RDATA 8'h08

`endif
